// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
TOP        ?= tb_env_gen
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== env_defines.svh ====
`ifndef ENV_DEFINES_SVH
`define ENV_DEFINES_SVH

`define ENV_VOICES      4
`define ENV_PER_VOICE   2
`define ENV_SLOTS       (`ENV_VOICES * `ENV_PER_VOICE)
`define ENV_VOICE_W     2
`define ENV_IDX_W       1
`define ENV_SLOT_W      3
`define ENV_ADR_W       4       // 8 bytes per envelope index
`define ENV_MAIN_IDX    0       // envelope that owns voice_free

// level accumulator, byte on top of the fraction
`define ENV_ACC_W       37
`define ENV_FRAC_W      29
`define ENV_NUM_SHIFT   22

// rate stages and sustain are consecutive codes
`define ENV_STG_W       3
`define ENV_ST_IDLE     3'd0
`define ENV_ST_RATE1    3'd1
`define ENV_ST_RATE2    3'd2
`define ENV_ST_RATE3    3'd3
`define ENV_ST_SUSTAIN  3'd4
`define ENV_ST_RELEASE  3'd5
`define ENV_ST_DONE     3'd6

`endif

// ==== env_gen.sv ====
`default_nettype none

`include "env_defines.svh"

module env_gen (
    input  wire                    reg_clk,
    input  wire                    reset,
    input  wire                    env_sel,
    input  wire                    write,
    input  wire                    read,
    input  wire [`ENV_ADR_W-1:0]   adr,
    input  wire [7:0]              wdata,
    input  wire [`ENV_VOICES-1:0]  keys,
    output logic [7:0]             rdata,
    output logic                   level_valid,
    output logic [`ENV_SLOT_W-1:0] level_slot,
    output logic [7:0]             level_out,
    output logic [`ENV_VOICES-1:0] voice_free
);

    logic [`ENV_SLOT_W-1:0]       slot;
    logic                         slot_valid;
    logic                         clear;
    logic [`ENV_IDX_W-1:0]        fetch_idx;
    logic [3:0][7:0]              rates;
    logic [3:0][7:0]              levels;
    logic [`ENV_STG_W-1:0]        rd_stage;
    env_pkg::env_level_u          rd_level;
    logic [7:0]                   rd_start;
    logic signed [`ENV_ACC_W-1:0] rd_slope;
    logic                         wr_en;
    logic [`ENV_SLOT_W-1:0]       wr_slot;
    logic [`ENV_STG_W-1:0]        wr_stage;
    env_pkg::env_level_u          wr_level;
    logic [7:0]                   wr_start;
    logic signed [`ENV_ACC_W-1:0] wr_slope;

    slot_sequencer u_seq (
        .reg_clk    (reg_clk),
        .reset      (reset),
        .slot       (slot),
        .slot_valid (slot_valid),
        .clear      (clear)
    );

    env_state_ram u_ram (
        .reg_clk  (reg_clk),
        .slot     (slot),
        .clear    (clear),
        .wr_en    (wr_en),
        .wr_slot  (wr_slot),
        .wr_stage (wr_stage),
        .wr_level (wr_level),
        .wr_start (wr_start),
        .wr_slope (wr_slope),
        .rd_stage (rd_stage),
        .rd_level (rd_level),
        .rd_start (rd_start),
        .rd_slope (rd_slope)
    );

    env_regs u_regs (
        .reg_clk   (reg_clk),
        .reset     (reset),
        .env_sel   (env_sel),
        .write     (write),
        .read      (read),
        .adr       (adr),
        .wdata     (wdata),
        .fetch_idx (fetch_idx),
        .rdata     (rdata),
        .rates     (rates),
        .levels    (levels)
    );

    env_stage_fsm u_fsm (
        .reg_clk     (reg_clk),
        .reset       (reset),
        .in_valid    (slot_valid),
        .in_slot     (slot),
        .keys        (keys),
        .rd_stage    (rd_stage),
        .rd_level    (rd_level),
        .rd_start    (rd_start),
        .rd_slope    (rd_slope),
        .rates       (rates),
        .levels      (levels),
        .fetch_idx   (fetch_idx),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_stage    (wr_stage),
        .wr_level    (wr_level),
        .wr_start    (wr_start),
        .wr_slope    (wr_slope),
        .level_valid (level_valid),
        .level_slot  (level_slot),
        .level_out   (level_out),
        .voice_free  (voice_free)
    );

endmodule

`default_nettype wire

// ==== env_gen_chk.sv ====
`default_nettype none

`include "env_defines.svh"

module env_gen_chk (
    input wire                    reg_clk,
    input wire                    reset,
    input wire                    clear,
    input wire                    level_valid,
    input wire [`ENV_SLOT_W-1:0]  level_slot,
    input wire [`ENV_VOICES-1:0]  voice_free
);

    timeunit 1ns;
    timeprecision 1ps;

    // nothing comes out while the state memory is being cleared
    a_quiet: assert property (@(posedge reg_clk) (reset || clear) |=> !level_valid)
        else $error("level_valid high during reset or the clear sweep");

    a_free_reset: assert property (@(posedge reg_clk) $fell(reset) |-> voice_free == '1)
        else $error("voice_free not all ones after reset");

    a_slot_order: assert property (@(posedge reg_clk) disable iff (reset)
        level_valid && $past(level_valid) |->
            int'(level_slot) == (int'($past(level_slot)) + 1) % `ENV_SLOTS)
        else $error("level_slot did not advance by one");   // one slot per cycle

endmodule

bind env_gen env_gen_chk chk (
    .reg_clk     (reg_clk),
    .reset       (reset),
    .clear       (clear),
    .level_valid (level_valid),
    .level_slot  (level_slot),
    .voice_free  (voice_free)
);

`default_nettype wire

// ==== env_pkg.sv ====
`default_nettype none

`include "env_defines.svh"

package env_pkg;

    // one accumulator word, added as a whole, read back as byte + fraction
    typedef union packed {
        logic signed [`ENV_ACC_W-1:0] raw;
        struct packed {
            logic [7:0]             lvl;    // output level and target compare
            logic [`ENV_FRAC_W-1:0] frac;
        } f;
    } env_level_u;

endpackage

`default_nettype wire

// ==== env_regs.sv ====
`default_nettype none

`include "env_defines.svh"

module env_regs (
    input  wire                   reg_clk,
    input  wire                   reset,
    input  wire                   env_sel,
    input  wire                   write,
    input  wire                   read,
    input  wire [`ENV_ADR_W-1:0]  adr,
    input  wire [7:0]             wdata,
    input  wire [`ENV_IDX_W-1:0]  fetch_idx,
    output logic [7:0]            rdata,
    output logic [3:0][7:0]       rates,
    output logic [3:0][7:0]       levels
);

    localparam int NREGS = 1 << `ENV_ADR_W;

    // adr = {env index, level/rate, stage number}
    logic [7:0] regs [NREGS];

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (env_sel && write) begin
            regs[adr] <= wdata;
        end
    end

    // read data stays until the next read
    always_ff @(posedge reg_clk) begin
        if (reset) begin
            rdata <= 8'h00;
        end else if (env_sel && read) begin
            rdata <= regs[adr];
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rates[i]  = regs[{fetch_idx, 1'b0, 2'(i)}];
            levels[i] = regs[{fetch_idx, 1'b1, 2'(i)}];
        end
    end

endmodule

`default_nettype wire

// ==== env_stage_fsm.sv ====
`default_nettype none

`include "env_defines.svh"

module env_stage_fsm (
    input  wire                           reg_clk,
    input  wire                           reset,
    input  wire                           in_valid,
    input  wire [`ENV_SLOT_W-1:0]         in_slot,
    input  wire [`ENV_VOICES-1:0]         keys,
    input  wire [`ENV_STG_W-1:0]          rd_stage,
    input  wire env_pkg::env_level_u      rd_level,
    input  wire [7:0]                     rd_start,
    input  wire signed [`ENV_ACC_W-1:0]   rd_slope,
    input  wire [3:0][7:0]                rates,
    input  wire [3:0][7:0]                levels,
    output logic [`ENV_IDX_W-1:0]         fetch_idx,
    output logic                          wr_en,
    output logic [`ENV_SLOT_W-1:0]        wr_slot,
    output logic [`ENV_STG_W-1:0]         wr_stage,
    output env_pkg::env_level_u           wr_level,
    output logic [7:0]                    wr_start,
    output logic signed [`ENV_ACC_W-1:0]  wr_slope,
    output logic                          level_valid,
    output logic [`ENV_SLOT_W-1:0]        level_slot,
    output logic [7:0]                    level_out,
    output logic [`ENV_VOICES-1:0]        voice_free
);

    logic                         v_q;
    logic [`ENV_SLOT_W-1:0]       s_q;
    logic [`ENV_VOICE_W-1:0]      voice;
    logic                         key;
    logic [7:0]                   cur_rate;
    logic [7:0]                   cur_tgt;
    logic signed [`ENV_ACC_W+1:0] sum;
    logic signed [9:0]            sum_lvl;
    logic                         reached;
    logic                         restart;
    logic [7:0]                   new_start;
    logic [7:0]                   new_rate;
    logic [7:0]                   new_tgt;
    logic signed [8:0]            diff;
    logic signed [`ENV_ACC_W-1:0] numer;
    logic [15:0]                  denom;

    // line up with the memory read
    always_ff @(posedge reg_clk) begin
        if (reset) begin
            v_q <= 1'b0;
        end else begin
            v_q <= in_valid;
        end
    end

    always_ff @(posedge reg_clk) begin
        s_q <= in_slot;
    end

    assign voice     = s_q[`ENV_SLOT_W-1:`ENV_IDX_W];
    assign fetch_idx = s_q[`ENV_IDX_W-1:0];
    assign key       = keys[voice];
    assign wr_en     = v_q;
    assign wr_slot   = s_q;

    always_comb begin
        case (rd_stage)
            `ENV_ST_RATE1: begin
                cur_rate = rates[0];
                cur_tgt  = levels[0];
            end
            `ENV_ST_RATE2: begin
                cur_rate = rates[1];
                cur_tgt  = levels[1];
            end
            `ENV_ST_RATE3: begin
                cur_rate = rates[2];
                cur_tgt  = levels[2];
            end
            default: begin     // release
                cur_rate = rates[3];
                cur_tgt  = levels[3];
            end
        endcase
        // two spare bits catch a step past 255 or below 0
        sum = $signed({2'b00, rd_level.raw}) + $signed({{2{rd_slope[`ENV_ACC_W-1]}}, rd_slope});
        sum_lvl = sum[`ENV_ACC_W+1:`ENV_FRAC_W];
        reached = (cur_rate == 8'd0) ||
                  ((cur_tgt >= rd_start) ? (sum_lvl >= $signed({2'b00, cur_tgt}))
                                         : (sum_lvl <= $signed({2'b00, cur_tgt})));
    end

    always_comb begin
        wr_stage  = rd_stage;
        wr_level  = rd_level;
        restart   = 1'b0;
        new_start = rd_level.f.lvl;
        case (rd_stage)
            `ENV_ST_IDLE: begin
                wr_level.raw = '0;
                if (key) begin
                    wr_stage  = `ENV_ST_RATE1;
                    restart   = 1'b1;
                    new_start = 8'h00;
                end
            end
            `ENV_ST_RATE1, `ENV_ST_RATE2, `ENV_ST_RATE3, `ENV_ST_RELEASE: begin
                if (key == (rd_stage == `ENV_ST_RELEASE)) begin
                    // key-off in attack/decay, key-on in release
                    wr_stage = key ? `ENV_ST_RATE1 : `ENV_ST_RELEASE;
                    restart  = 1'b1;
                end else if (reached) begin
                    wr_level.f.lvl  = cur_tgt;
                    wr_level.f.frac = '0;
                    wr_stage  = (rd_stage == `ENV_ST_RELEASE) ? `ENV_ST_DONE : rd_stage + 1'b1;
                    restart   = 1'b1;
                    new_start = cur_tgt;
                end else begin
                    wr_level.raw = sum[`ENV_ACC_W-1:0];
                end
            end
            `ENV_ST_SUSTAIN: begin
                if (!key) begin
                    wr_stage = `ENV_ST_RELEASE;
                    restart  = 1'b1;
                end
            end
            `ENV_ST_DONE: begin
                if (key) begin     // re-trigger wins over the return to idle
                    wr_stage = `ENV_ST_RATE1;
                    restart  = 1'b1;
                end else if (levels[3] == 8'h00) begin
                    wr_stage     = `ENV_ST_IDLE;
                    wr_level.raw = '0;
                    restart      = 1'b1;
                    new_start    = 8'h00;
                end
            end
            default: begin
                wr_stage     = `ENV_ST_IDLE;
                wr_level.raw = '0;
                restart      = 1'b1;
                new_start    = 8'h00;
            end
        endcase
    end

    // slope for the stage being entered; flat stages get zero
    always_comb begin
        case (wr_stage)
            `ENV_ST_RATE1: begin
                new_rate = rates[0];
                new_tgt  = levels[0];
            end
            `ENV_ST_RATE2: begin
                new_rate = rates[1];
                new_tgt  = levels[1];
            end
            `ENV_ST_RATE3: begin
                new_rate = rates[2];
                new_tgt  = levels[2];
            end
            `ENV_ST_RELEASE: begin
                new_rate = rates[3];
                new_tgt  = levels[3];
            end
            default: begin
                new_rate = 8'h00;
                new_tgt  = new_start;
            end
        endcase
        diff  = $signed({1'b0, new_tgt}) - $signed({1'b0, new_start});
        numer = {{(`ENV_ACC_W-9){diff[8]}}, diff} <<< `ENV_NUM_SHIFT;
        denom = (new_rate == 8'h00) ? 16'd1 : new_rate * new_rate;
        wr_start = restart ? new_start : rd_start;
        wr_slope = restart ? numer / $signed({1'b0, denom}) : rd_slope;
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            level_valid <= 1'b0;
            voice_free  <= '1;
        end else begin
            level_valid <= v_q;
            if (v_q && fetch_idx == `ENV_MAIN_IDX) begin
                voice_free[voice] <= (wr_stage == `ENV_ST_IDLE) || (wr_stage == `ENV_ST_DONE);
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        level_slot <= s_q;
        level_out  <= wr_level.f.lvl;
    end

endmodule

`default_nettype wire

// ==== env_state_ram.sv ====
`default_nettype none

`include "env_defines.svh"

module env_state_ram (
    input  wire                           reg_clk,
    input  wire [`ENV_SLOT_W-1:0]         slot,
    input  wire                           clear,
    input  wire                           wr_en,
    input  wire [`ENV_SLOT_W-1:0]         wr_slot,
    input  wire [`ENV_STG_W-1:0]          wr_stage,
    input  wire env_pkg::env_level_u      wr_level,
    input  wire [7:0]                     wr_start,
    input  wire signed [`ENV_ACC_W-1:0]   wr_slope,
    output logic [`ENV_STG_W-1:0]         rd_stage,
    output env_pkg::env_level_u           rd_level,
    output logic [7:0]                    rd_start,
    output logic signed [`ENV_ACC_W-1:0]  rd_slope
);

    logic [`ENV_STG_W-1:0]        stage_mem [`ENV_SLOTS];
    env_pkg::env_level_u          level_mem [`ENV_SLOTS];
    logic [7:0]                   start_mem [`ENV_SLOTS];
    logic signed [`ENV_ACC_W-1:0] slope_mem [`ENV_SLOTS];

    always_ff @(posedge reg_clk) begin
        if (clear) begin
            stage_mem[slot] <= `ENV_ST_IDLE;    // init sweep, idle at zero
            level_mem[slot] <= '0;
            start_mem[slot] <= 8'h00;
            slope_mem[slot] <= '0;
        end else if (wr_en) begin
            stage_mem[wr_slot] <= wr_stage;
            level_mem[wr_slot] <= wr_level;
            start_mem[wr_slot] <= wr_start;
            slope_mem[wr_slot] <= wr_slope;
        end
        rd_stage <= stage_mem[slot];
        rd_level <= level_mem[slot];
        rd_start <= start_mem[slot];
        rd_slope <= slope_mem[slot];
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
env_pkg.sv
env_regs.sv
slot_sequencer.sv
env_state_ram.sv
env_stage_fsm.sv
env_gen.sv
env_gen_chk.sv
tb_env_gen.sv

// ==== slot_sequencer.sv ====
`default_nettype none

`include "env_defines.svh"

module slot_sequencer (
    input  wire                    reg_clk,
    input  wire                    reset,
    output logic [`ENV_SLOT_W-1:0] slot,
    output logic                   slot_valid,
    output logic                   clear
);

    // one pass over all slots with clear set, then free running
    always_ff @(posedge reg_clk) begin
        if (reset) begin
            slot  <= '0;
            clear <= 1'b1;
        end else begin
            slot <= slot + 1'b1;    // slot count is a power of two, wraps
            if (clear && slot == (`ENV_SLOTS - 1)) begin
                clear <= 1'b0;
            end
        end
    end

    assign slot_valid = ~clear;

endmodule

`default_nettype wire

// ==== tb_env_gen.sv ====
`default_nettype none

`include "env_defines.svh"

module tb_env_gen;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NREGS     = 1 << `ENV_ADR_W;
    localparam int RESET_CYC = 16;
    localparam int FIRST_OUT = `ENV_SLOTS + 3;  // release cycle, clear sweep, two pipe stages
    localparam int FREE_WAIT = 5000;            // rate 2 release needs about 4100 cycles
    localparam int N_PAT     = 60;
    localparam int T1_CYC    = 60;
    localparam int T2_CYC    = 120;
    localparam int T3_CYC    = 4100;
    localparam int T4_CYC    = FREE_WAIT + 100;
    localparam int T5_CYC    = 520 + N_PAT * 72;
    localparam int WDOG_CYC  = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 500;

    logic                    reg_clk;
    logic                    reset;
    logic                    env_sel;
    logic                    write;
    logic                    read;
    logic [`ENV_ADR_W-1:0]   adr;
    logic [7:0]              wdata;
    logic [`ENV_VOICES-1:0]  keys;
    logic [7:0]              rdata;
    logic                    level_valid;
    logic [`ENV_SLOT_W-1:0]  level_slot;
    logic [7:0]              level_out;
    logic [`ENV_VOICES-1:0]  voice_free;

    // reference model state
    int                      seed;
    int                      errors;
    string                   test_name;
    int                      mregs [NREGS];
    int                      regs_prev [NREGS];   // bytes seen by the slot in evaluation
    logic [`ENV_STG_W-1:0]   m_stage [`ENV_SLOTS];
    longint                  m_acc [`ENV_SLOTS];
    int                      m_start [`ENV_SLOTS];
    longint                  m_slope [`ENV_SLOTS];
    logic [`ENV_VOICES-1:0]  m_free;
    logic [`ENV_VOICES-1:0]  keys_prev;
    int                      mslot;
    int                      ncyc;
    int                      rd_exp;              // rdata holds until the next read

    env_gen uut (
        .reg_clk     (reg_clk),
        .reset       (reset),
        .env_sel     (env_sel),
        .write       (write),
        .read        (read),
        .adr         (adr),
        .wdata       (wdata),
        .keys        (keys),
        .rdata       (rdata),
        .level_valid (level_valid),
        .level_slot  (level_slot),
        .level_out   (level_out),
        .voice_free  (voice_free)
    );

    always #20 reg_clk = ~reg_clk;

    task automatic check_equal(input string what, input int exp, input int act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s / %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // one visit of slot s by the envelope rules
    task automatic model_step(input int s, output logic [7:0] lvl);
        int                    voice;
        int                    base;
        int                    i;
        int                    rate;
        int                    tgt;
        int                    nrate;
        int                    ntgt;
        int                    nstart;
        int                    den;
        int                    sum_lvl;
        longint                sum;
        logic                  key;
        logic                  restart;
        logic [`ENV_STG_W-1:0] st;
        logic [`ENV_STG_W-1:0] nst;
        voice   = s >> `ENV_IDX_W;
        base    = (s % `ENV_PER_VOICE) * 8;
        key     = keys_prev[voice];
        st      = m_stage[s];
        nst     = st;
        restart = 1'b0;
        nstart  = int'(m_acc[s] >>> `ENV_FRAC_W);
        i       = (st >= `ENV_ST_RATE1 && st <= `ENV_ST_RATE3) ? int'(st) - 1 : 3;
        rate    = regs_prev[base + i];
        tgt     = regs_prev[base + 4 + i];
        sum     = m_acc[s] + m_slope[s];
        sum_lvl = int'(sum >>> `ENV_FRAC_W);
        case (st)
            `ENV_ST_IDLE: begin
                m_acc[s] = 0;
                if (key) begin
                    nst     = `ENV_ST_RATE1;
                    restart = 1'b1;
                    nstart  = 0;
                end
            end
            `ENV_ST_RATE1, `ENV_ST_RATE2, `ENV_ST_RATE3, `ENV_ST_RELEASE: begin
                if (key == (st == `ENV_ST_RELEASE)) begin
                    nst     = key ? `ENV_ST_RATE1 : `ENV_ST_RELEASE;
                    restart = 1'b1;
                end else if (rate == 0 ||
                             ((tgt >= m_start[s]) ? (sum_lvl >= tgt) : (sum_lvl <= tgt))) begin
                    m_acc[s] = longint'(tgt) <<< `ENV_FRAC_W;    // clamp to target
                    nst      = (st == `ENV_ST_RELEASE) ? `ENV_ST_DONE : st + 3'd1;
                    restart  = 1'b1;
                    nstart   = tgt;
                end else begin
                    m_acc[s] = sum;
                end
            end
            `ENV_ST_SUSTAIN: begin
                if (!key) begin
                    nst     = `ENV_ST_RELEASE;
                    restart = 1'b1;
                end
            end
            default: begin
                if (key) begin
                    nst     = `ENV_ST_RATE1;
                    restart = 1'b1;
                end else if (regs_prev[base + 7] == 0) begin
                    nst      = `ENV_ST_IDLE;
                    m_acc[s] = 0;
                    restart  = 1'b1;
                    nstart   = 0;
                end
            end
        endcase
        if (restart) begin
            if ((nst >= `ENV_ST_RATE1 && nst <= `ENV_ST_RATE3) || nst == `ENV_ST_RELEASE) begin
                i     = (nst == `ENV_ST_RELEASE) ? 3 : int'(nst) - 1;
                nrate = regs_prev[base + i];
                ntgt  = regs_prev[base + 4 + i];
            end else begin
                nrate = 0;      // flat stage
                ntgt  = nstart;
            end
            den        = (nrate == 0) ? 1 : nrate * nrate;
            m_start[s] = nstart;
            m_slope[s] = (longint'(ntgt - nstart) <<< `ENV_NUM_SHIFT) / longint'(den);
        end
        m_stage[s] = nst;
        if (s % `ENV_PER_VOICE == `ENV_MAIN_IDX) begin
            m_free[voice] = (nst == `ENV_ST_IDLE) || (nst == `ENV_ST_DONE);
        end
        lvl = 8'(m_acc[s] >>> `ENV_FRAC_W);
    endtask

    // outputs are compared at the falling edge
    always @(negedge reg_clk) begin
        logic [7:0] exp_lvl;
        if (reset) begin
            for (int s = 0; s < `ENV_SLOTS; s++) begin
                m_stage[s] = `ENV_ST_IDLE;
                m_acc[s]   = 0;
                m_start[s] = 0;
                m_slope[s] = 0;
            end
            foreach (mregs[i]) begin
                mregs[i] = 0;
            end
            m_free = '1;
            mslot  = 0;
            ncyc   = 0;
            rd_exp = 0;
        end else begin
            ncyc++;
            check_equal("rdata", rd_exp, int'(rdata));
            check_equal("level_valid", int'(ncyc >= FIRST_OUT), int'(level_valid));
            if (ncyc >= FIRST_OUT) begin
                model_step(mslot, exp_lvl);
                check_equal("level_slot", mslot, int'(level_slot));
                check_equal("level_out", int'(exp_lvl), int'(level_out));
                mslot = (mslot + 1) % `ENV_SLOTS;
            end
            check_equal("voice_free", int'(m_free), int'(voice_free));
        end
        regs_prev = mregs;
        keys_prev = keys;
        if (!reset && env_sel && read) begin
            rd_exp = mregs[adr];   // old byte if written in the same cycle
        end
        if (!reset && env_sel && write) begin
            mregs[adr] = int'(wdata);
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge reg_clk);
    endtask

    task automatic bus_write(input int a, input int d);
        @(posedge reg_clk);
        #2;
        env_sel = 1'b1;
        write   = 1'b1;
        read    = 1'b0;
        adr     = 4'(a);
        wdata   = 8'(d);
    endtask

    task automatic bus_read(input int a);
        @(posedge reg_clk);
        #2;
        env_sel = 1'b1;
        write   = 1'b0;
        read    = 1'b1;
        adr     = 4'(a);
    endtask

    task automatic bus_idle();
        @(posedge reg_clk);
        #2;
        env_sel = 1'b0;
        write   = 1'b0;
        read    = 1'b0;
    endtask

    task automatic set_keys(input logic [`ENV_VOICES-1:0] k);
        @(posedge reg_clk);
        #2;
        keys = k;
    endtask

    initial begin
        #(WDOG_CYC * 40);
        $display("watchdog expired after %0d cycles, the test sequence did not finish", WDOG_CYC);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        int rnd;
        int r;
        int n;
        seed      = 32'h71531b75;
        errors    = 0;
        test_name = "reset";
        reg_clk   = 1'b0;
        reset     = 1'b1;
        env_sel   = 1'b0;
        write     = 1'b0;
        read      = 1'b0;
        adr       = '0;
        wdata     = '0;
        keys      = '0;
        repeat (RESET_CYC) @(posedge reg_clk);
        #2;
        reset = 1'b0;
        idle_cycles(`ENV_SLOTS + 4);

        test_name = "register access";
        for (int a = 0; a < NREGS; a++) begin
            rnd = $random(seed);
            bus_write(a, rnd & 255);
        end
        for (int a = 0; a < NREGS; a++) begin
            bus_read(a);
        end
        bus_idle();
        idle_cycles(4);

        test_name = "zero-rate jumps";
        for (int a = 0; a < NREGS; a++) begin
            rnd = $random(seed);
            bus_write(a, a[2] ? (rnd & 255) : 0);   // bit 2 picks the level bytes
        end
        bus_idle();
        set_keys(4'hf);
        idle_cycles(6 * `ENV_SLOTS);
        @(negedge reg_clk);
        check_equal("voice_free held", 0, int'(voice_free));
        set_keys(4'h0);
        idle_cycles(3 * `ENV_SLOTS);

        test_name = "sloped attack";
        for (int a = 0; a < NREGS; a++) begin
            rnd = $random(seed);
            bus_write(a, a[2] ? (rnd & 255) : 1 + (rnd & 1));
        end
        bus_idle();
        set_keys(4'hf);
        idle_cycles(4000);

        test_name = "release and freeing";
        rnd = $random(seed);
        bus_write(3, 1 + (rnd & 1));
        bus_write(11, 2 - (rnd & 1));
        bus_write(7, 0);
        bus_write(15, 0);
        bus_idle();
        set_keys(4'h0);
        n = 0;
        while (voice_free != 4'hf && n < FREE_WAIT) begin
            @(negedge reg_clk);
            n++;
        end
        if (n >= FREE_WAIT) begin
            $display("voice_free did not return to all ones within %0d cycles", FREE_WAIT);
            $display("Result: FAILED");
            $fatal(1, "release never finished");
        end
        idle_cycles(3 * `ENV_SLOTS);

        test_name = "re-trigger";
        for (int a = 0; a < NREGS; a++) begin
            rnd = $random(seed);
            r   = rnd & 3;
            bus_write(a, a[2] ? ((rnd >>> 8) & 255) : ((r == 3) ? 1 : r));
        end
        bus_idle();
        set_keys(4'hf);
        idle_cycles(200);
        set_keys(4'h0);
        idle_cycles(80);    // mid release
        set_keys(4'hf);
        idle_cycles(200);
        for (int i = 0; i < N_PAT; i++) begin
            rnd = $random(seed);
            set_keys(4'(rnd));
            idle_cycles(8 + ((rnd >>> 4) & 63));
        end
        idle_cycles(2 * `ENV_SLOTS);

        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
